// ==== hdl/aabb_test.sv ====
`timescale 1ns/1ps

module aabb_test (
  input  logic                clk,
  input  logic                rst,
  input  geom_pkg::triangle_t tri_data,
  input  cull_pkg::tri_id_t   tri_id,
  input  logic                tri_rdy,
  input  geom_pkg::box_t      query,
  output cull_pkg::verdict_t  verdict
);

  import geom_pkg::*;

  box_t tri_box;
  logic overlap;

  function automatic logic signed [COORD_W-1:0] min3(
    input logic signed [COORD_W-1:0] a,
    input logic signed [COORD_W-1:0] b,
    input logic signed [COORD_W-1:0] c
  );
    logic signed [COORD_W-1:0] m;
    m = (a < b) ? a : b;
    return (c < m) ? c : m;
  endfunction

  function automatic logic signed [COORD_W-1:0] max3(
    input logic signed [COORD_W-1:0] a,
    input logic signed [COORD_W-1:0] b,
    input logic signed [COORD_W-1:0] c
  );
    logic signed [COORD_W-1:0] m;
    m = (a > b) ? a : b;
    return (c > m) ? c : m;
  endfunction

  always_comb begin
    tri_box.lo.x = min3(tri_data.v0.x, tri_data.v1.x, tri_data.v2.x);
    tri_box.lo.y = min3(tri_data.v0.y, tri_data.v1.y, tri_data.v2.y);
    tri_box.lo.z = min3(tri_data.v0.z, tri_data.v1.z, tri_data.v2.z);
    tri_box.hi.x = max3(tri_data.v0.x, tri_data.v1.x, tri_data.v2.x);
    tri_box.hi.y = max3(tri_data.v0.y, tri_data.v1.y, tri_data.v2.y);
    tri_box.hi.z = max3(tri_data.v0.z, tri_data.v1.z, tri_data.v2.z);
  end

  // touching faces still overlap.
  assign overlap = (tri_box.lo.x <= query.hi.x) && (tri_box.hi.x >= query.lo.x) &&
                   (tri_box.lo.y <= query.hi.y) && (tri_box.hi.y >= query.lo.y) &&
                   (tri_box.lo.z <= query.hi.z) && (tri_box.hi.z >= query.lo.z);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      verdict <= '0;
    end else begin
      verdict.valid <= tri_rdy;
      if (tri_rdy) begin
        verdict.pass <= overlap;
        verdict.id   <= tri_id;
      end
    end
  end

endmodule

// ==== hdl/cull_merge.sv ====
`timescale 1ns/1ps

module cull_merge (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clear,
  input  cull_pkg::verdict_t             box_v,
  input  cull_pkg::verdict_t             shade_v,
  output cull_pkg::hit_t                 result,
  output logic [cull_pkg::HIT_CNT_W-1:0] hit_count
);

  logic hit_now;
  logic mismatch;
  logic mismatch_err;

  assign hit_now = box_v.valid && box_v.pass && shade_v.pass;

  // both tests see the same triangle in the same cycle.
  assign mismatch = (box_v.valid != shade_v.valid) ||
                    (box_v.valid && (box_v.id != shade_v.id));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result       <= '0;
      mismatch_err <= 1'b0;
    end else begin
      result.valid <= box_v.valid;
      result.hit   <= hit_now;
      if (box_v.valid) begin
        result.id <= box_v.id;
      end
      if (mismatch) begin
        mismatch_err <= 1'b1; // sticky until reset.
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hit_count <= '0;
    end else if (clear) begin
      hit_count <= '0;
    end else if (hit_now && (hit_count != '1)) begin
      hit_count <= hit_count + 1'b1; // saturates.
    end
  end

endmodule

// ==== hdl/cull_pkg.sv ====
package cull_pkg;

  // scene store depth.
  localparam int NUM_TRIANGLE = 16;
  localparam int TRI_ID_W = $clog2(NUM_TRIANGLE);

  localparam int HIT_CNT_W = 8; // saturating hit counter.

  typedef logic [TRI_ID_W-1:0] tri_id_t;

  // per test result, one per triangle.
  typedef struct packed {
    logic    valid;
    logic    pass;
    tri_id_t id;
  } verdict_t;

  // merged result seen at the top level.
  typedef struct packed {
    logic    valid;
    logic    hit;
    tri_id_t id;
  } hit_t;

endpackage

// ==== hdl/geom_pkg.sv ====
package geom_pkg;

  localparam int COORD_W = 32;

  // signed fixed point coordinates.
  typedef struct packed {
    logic signed [COORD_W-1:0] x;
    logic signed [COORD_W-1:0] y;
    logic signed [COORD_W-1:0] z;
  } vertex_t;

  // three vertices plus the shader id.
  typedef struct packed {
    vertex_t     v0;
    vertex_t     v1;
    vertex_t     v2;
    logic [31:0] sid;
  } triangle_t;

  // axis aligned box, lo corner first.
  typedef struct packed {
    vertex_t lo;
    vertex_t hi;
  } box_t;

endpackage

// ==== hdl/shader_filter.sv ====
`timescale 1ns/1ps

module shader_filter (
  input  logic                clk,
  input  logic                rst,
  input  geom_pkg::triangle_t tri_data,
  input  cull_pkg::tri_id_t   tri_id,
  input  logic                tri_rdy,
  input  logic [31:0]         shader_mask,
  output cull_pkg::verdict_t  verdict
);

  logic sid_ok;
  logic enabled;

  // only 32 shaders exist, anything above is invalid.
  assign sid_ok  = (tri_data.sid[31:5] == '0);
  assign enabled = sid_ok && shader_mask[tri_data.sid[4:0]];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      verdict <= '0;
    end else begin
      verdict.valid <= tri_rdy;
      if (tri_rdy) begin
        verdict.pass <= enabled;
        verdict.id   <= tri_id;
      end
    end
  end

endmodule

// ==== hdl/tri_cull_top.sv ====
`timescale 1ns/1ps

module tri_cull_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           clear,
  input  logic                           fetch,
  input  logic                           wr_en,
  input  cull_pkg::tri_id_t              wr_addr,
  input  geom_pkg::triangle_t            wr_data,
  input  geom_pkg::box_t                 query,
  input  logic [31:0]                    shader_mask,
  output cull_pkg::hit_t                 result,
  output logic [cull_pkg::HIT_CNT_W-1:0] hit_count,
  output logic                           mem_busy
);

  import geom_pkg::*;
  import cull_pkg::*;

  logic      mem_en;
  logic      mem_rdy;
  tri_id_t   mem_addr;
  triangle_t mem_data;
  triangle_t tri_data;
  tri_id_t   tri_id;
  logic      tri_rdy;
  verdict_t  box_v;
  verdict_t  shade_v;

  tri_mem tri_mem_inst (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .mem_en   (mem_en),
    .mem_addr (mem_addr),
    .mem_rdy  (mem_rdy),
    .mem_data (mem_data),
    .mem_busy (mem_busy)
  );

  tri_manager tri_manager_inst (
    .clk      (clk),
    .rst      (rst),
    .fetch    (fetch),
    .clear    (clear),
    .mem_rdy  (mem_rdy),
    .mem_busy (mem_busy),
    .mem_data (mem_data),
    .mem_en   (mem_en),
    .mem_addr (mem_addr),
    .tri_data (tri_data),
    .tri_id   (tri_id),
    .tri_rdy  (tri_rdy)
  );

  // both tests run on the same held triangle.
  aabb_test aabb_test_inst (
    .clk      (clk),
    .rst      (rst),
    .tri_data (tri_data),
    .tri_id   (tri_id),
    .tri_rdy  (tri_rdy),
    .query    (query),
    .verdict  (box_v)
  );

  shader_filter shader_filter_inst (
    .clk         (clk),
    .rst         (rst),
    .tri_data    (tri_data),
    .tri_id      (tri_id),
    .tri_rdy     (tri_rdy),
    .shader_mask (shader_mask),
    .verdict     (shade_v)
  );

  cull_merge cull_merge_inst (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .box_v     (box_v),
    .shade_v   (shade_v),
    .result    (result),
    .hit_count (hit_count)
  );

endmodule

// ==== hdl/tri_manager.sv ====
`timescale 1ns/1ps

module tri_manager (
  input  logic                clk,
  input  logic                rst,
  input  logic                fetch,
  input  logic                clear,
  input  logic                mem_rdy,
  input  logic                mem_busy,
  input  geom_pkg::triangle_t mem_data,
  output logic                mem_en,
  output cull_pkg::tri_id_t   mem_addr,
  output geom_pkg::triangle_t tri_data,
  output cull_pkg::tri_id_t   tri_id,
  output logic                tri_rdy
);

  import cull_pkg::*;

  typedef enum logic {
    IDLE,
    FTCH
  } state_t;

  state_t  state;
  state_t  nxt_state;
  tri_id_t next_id;
  logic    ld;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  // read request goes out in the same cycle as fetch when the store is free.
  always_comb begin
    mem_en    = 1'b0;
    ld        = 1'b0;
    nxt_state = state;
    case (state)
      FTCH: begin
        if (mem_rdy) begin
          ld        = 1'b1;
          nxt_state = IDLE;
        end else if (!mem_busy) begin
          mem_en = 1'b1; // retry after a host write.
        end
      end
      default: begin
        if (fetch) begin
          mem_en    = !mem_busy;
          nxt_state = FTCH;
        end
      end
    endcase
  end

  assign mem_addr = next_id;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      next_id <= '0;
      tri_rdy <= 1'b0;
    end else begin
      tri_rdy <= ld;
      if (clear) begin
        next_id <= '0;
      end else if (ld) begin
        if (next_id == TRI_ID_W'(NUM_TRIANGLE - 1)) begin
          next_id <= '0;
        end else begin
          next_id <= next_id + 1'b1;
        end
      end
    end
  end

  // held triangle keeps the id it was read from.
  always_ff @(posedge clk) begin
    if (clear) begin
      tri_data <= '0;
      tri_id   <= '0;
    end else if (ld) begin
      tri_data <= mem_data;
      tri_id   <= next_id;
    end
  end

endmodule

// ==== hdl/tri_mem.sv ====
`timescale 1ns/1ps

module tri_mem (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en,
  input  cull_pkg::tri_id_t   wr_addr,
  input  geom_pkg::triangle_t wr_data,
  input  logic                mem_en,
  input  cull_pkg::tri_id_t   mem_addr,
  output logic                mem_rdy,
  output geom_pkg::triangle_t mem_data,
  output logic                mem_busy
);

  import geom_pkg::*;
  import cull_pkg::*;

  triangle_t store [NUM_TRIANGLE];
  logic      rd_go;

  // host write wins over a read in the same cycle.
  assign rd_go = mem_en && !wr_en && !mem_busy;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      store[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_go) begin
      mem_data <= store[mem_addr]; // one cycle read.
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      mem_rdy  <= 1'b0;
      mem_busy <= 1'b0;
    end else begin
      mem_rdy  <= rd_go;
      mem_busy <= wr_en; // store not valid right after a write.
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tri_cull_top.f \
    --top-module tri_cull_tb -o tri_cull_sim; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tri_cull_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tri_cull_top.f ====
hdl/geom_pkg.sv
hdl/cull_pkg.sv
hdl/tri_mem.sv
hdl/tri_manager.sv
hdl/aabb_test.sv
hdl/shader_filter.sv
hdl/cull_merge.sv
hdl/tri_cull_top.sv
verification/tri_cull_chk.sv
verification/tri_cull_tb.sv

// ==== verification/tri_cull_chk.sv ====
`timescale 1ns/1ps

module tri_cull_chk (
  input logic clk,
  input logic rst,
  input logic fetch,
  input logic state,
  input logic mem_en,
  input logic mem_busy,
  input logic mem_rdy,
  input logic tri_rdy
);

  int fail_count = 0;

  // no read request toward a busy store.
  no_req_when_busy: assert property (@(posedge clk) disable iff (rst) !(mem_en && mem_busy))
    else begin
      $error("mem_en high while mem_busy is high");
      fail_count++;
    end

  rdy_after_mem: assert property (@(posedge clk) disable iff (rst) mem_rdy |=> tri_rdy)
    else begin
      $error("tri_rdy missing one cycle after mem_rdy");
      fail_count++;
    end

  rdy_only_after_mem: assert property (@(posedge clk) disable iff (rst)
                                       tri_rdy |-> $past(mem_rdy))
    else begin
      $error("tri_rdy without mem_rdy one cycle before");
      fail_count++;
    end

  // idle encodes as 0, a request there needs a fetch.
  idle_quiet: assert property (@(posedge clk) disable iff (rst)
                               (state == 1'b0 && !fetch) |-> !mem_en)
    else begin
      $error("mem_en high in idle without fetch");
      fail_count++;
    end

endmodule

bind tri_manager tri_cull_chk tri_cull_chk_inst (
  .clk      (clk),
  .rst      (rst),
  .fetch    (fetch),
  .state    (state),
  .mem_en   (mem_en),
  .mem_busy (mem_busy),
  .mem_rdy  (mem_rdy),
  .tri_rdy  (tri_rdy)
);

// ==== verification/tri_cull_tb.sv ====
`timescale 1ns/1ps

module tri_cull_tb;

  import geom_pkg::*;
  import cull_pkg::*;

  localparam int TRI_WORDS = 11;
  localparam int NUM_WORDS = 7 + NUM_TRIANGLE * TRI_WORDS;
  localparam int WAIT_MAX = 40;
  localparam int WATCH_CYCLES = WAIT_MAX * (3 * NUM_TRIANGLE + 2);

  logic                 clk;
  logic                 rst;
  logic                 clear;
  logic                 fetch;
  logic                 wr_en;
  tri_id_t              wr_addr;
  triangle_t            wr_data;
  box_t                 query;
  logic [31:0]          shader_mask;
  hit_t                 result;
  logic [HIT_CNT_W-1:0] hit_count;
  logic                 mem_busy;

  logic [31:0] vec [NUM_WORDS];
  logic        exp_hit [NUM_TRIANGLE];
  hit_t        exp_q [$];
  hit_t        exp_r;
  tri_id_t     model_id;
  int          exp_count;
  int          lat;
  int          gap;
  logic [31:0] lfsr = 32'hd0d;

  tri_cull_top tri_cull_top_inst (
    .clk         (clk),
    .rst         (rst),
    .clear       (clear),
    .fetch       (fetch),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .query       (query),
    .shader_mask (shader_mask),
    .result      (result),
    .hit_count   (hit_count),
    .mem_busy    (mem_busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Regression failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1, "simulation stopped");
    end
  endtask

  // fibonacci taps 32 22 2 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic triangle_t file_triangle(input int i);
    int        b;
    triangle_t t;
    b = 7 + i * TRI_WORDS;
    t.v0 = {vec[b], vec[b+1], vec[b+2]};
    t.v1 = {vec[b+3], vec[b+4], vec[b+5]};
    t.v2 = {vec[b+6], vec[b+7], vec[b+8]};
    t.sid = vec[b+9];
    return t;
  endfunction

  // shader lookup and per axis extent against the query.
  function automatic logic model_hit(input int i);
    int                 b;
    logic [31:0]        sid;
    logic [31:0]        mask;
    logic signed [31:0] c;
    logic signed [31:0] lo;
    logic signed [31:0] hi;
    logic               ok;
    b = 7 + i * TRI_WORDS;
    sid = vec[b+9];
    mask = vec[6];
    ok = (sid < 32) && mask[sid[4:0]];
    for (int a = 0; a < 3; a++) begin
      lo = vec[b+a];
      hi = lo;
      for (int v = 1; v < 3; v++) begin
        c = vec[b + 3*v + a];
        if (c < lo) lo = c;
        if (c > hi) hi = c;
      end
      if (lo > $signed(vec[3+a]) || hi < $signed(vec[a])) ok = 1'b0;
    end
    return ok;
  endfunction

  task automatic push_expected();
    hit_t e;
    e.valid = 1'b1;
    e.hit = exp_hit[model_id];
    e.id = model_id;
    exp_q.push_back(e);
    if (exp_hit[model_id]) exp_count++;
    model_id++; // wraps with the store depth.
  endtask

  task automatic fetch_and_wait(input logic with_write, output int n);
    push_expected();
    fetch = 1'b1;
    wr_en = with_write;
    n = 0;
    do begin
      tick();
      n++;
      fetch = 1'b0;
      wr_en = 1'b0;
      if (with_write && n == 1) check_value("mem_busy", mem_busy, 1);
      if (n > WAIT_MAX) abort_run("no result after a fetch");
    end while (!result.valid);
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    tick();
    clear = 1'b0;
    model_id = '0;
    exp_count = 0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      tick();
      n++;
      if (n > WAIT_MAX) abort_run("results missing after back to back fetches");
    end
  endtask

  always @(negedge clk) begin
    if (tri_cull_top_inst.tri_manager_inst.tri_cull_chk_inst.fail_count != 0) begin
      abort_run("fetch protocol assertion failed");
    end else if (!rst && result.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("result seen with no fetch outstanding");
      end else begin
        exp_r = exp_q.pop_front();
        check_value("result.id", result.id, exp_r.id);
        check_value("result.hit", result.hit, exp_r.hit);
      end
    end
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    rst = 1'b1;
    clear = 1'b0;
    fetch = 1'b0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    model_id = '0;
    exp_count = 0;
    $readmemh("verification/tri_cull_tests.txt", vec);
    query = {vec[0], vec[1], vec[2], vec[3], vec[4], vec[5]};
    shader_mask = vec[6];
    for (int i = 0; i < NUM_TRIANGLE; i++) begin
      exp_hit[i] = model_hit(i);
      check_value("file hit flag", vec[7 + i*TRI_WORDS + 10], exp_hit[i]);
    end
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    check_value("result.valid", result.valid, 0);
    check_value("mem_busy", mem_busy, 0);
    check_value("hit_count", hit_count, 0);

    for (int i = 0; i < NUM_TRIANGLE; i++) begin
      wr_en = 1'b1;
      wr_addr = tri_id_t'(i);
      wr_data = file_triangle(i);
      tick();
    end
    wr_en = 1'b0;
    tick();
    pulse_clear();

    for (int i = 0; i < NUM_TRIANGLE; i++) begin
      fetch_and_wait(1'b0, lat);
      check_value("latency", lat, 4);
    end
    check_value("hit_count", hit_count, exp_count);

    // host rewrites an entry with unchanged data while a fetch starts.
    wr_addr = tri_id_t'(5);
    wr_data = file_triangle(5);
    fetch_and_wait(1'b1, lat);
    check_value("late result", lat > 4, 1);
    check_value("hit_count", hit_count, exp_count);

    pulse_clear();
    for (int i = 0; i < NUM_TRIANGLE; i++) begin
      push_expected();
      fetch = 1'b1;
      tick();
      fetch = 1'b0;
      tick();
      take_bits(2, gap);
      repeat (gap) tick();
    end
    wait_drain();
    check_value("hit_count", hit_count, exp_count);

    pulse_clear();
    check_value("hit_count", hit_count, 0);
    fetch_and_wait(1'b0, lat);
    check_value("latency", lat, 4);
    tick();
    check_value("mismatch_err", tri_cull_top_inst.cull_merge_inst.mismatch_err, 0);

    if (exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run("results left unchecked at the end");
    end
  end

endmodule

// ==== verification/tri_cull_tests.txt ====
// line 1: query box lo x y z, hi x y z. line 2: 32-bit shader mask.
// then one triangle per line: v0 x y z, v1 x y z, v2 x y z, sid, expected hit.
0 0 0 64 64 64
800000f3
a a a 14 a a a 14 a 0 1
a a a 14 a a a 14 a 2 0
64 32 32 96 32 32 78 3c 32 1 1
65 32 32 96 32 32 78 3c 32 1 0
a a ffffffce 14 a fffffff6 a 14 0 4 1
a a ffffffce 14 a fffffff6 a 14 ffffffff 4 0
ffffffce ffffffce ffffffce c8 c8 c8 ffffffce c8 32 5 1
a a a 14 a a a 14 a 20 0
a a a 14 a a a 14 a 80000001 0
1e 1e 1e 32 1e 1e 1e 32 1e 7 1
a fffffff6 a 14 ffffffce a a ffffffff a 0 0
64 64 64 c8 96 96 96 c8 c8 6 1
1e 1e 1e 32 1e 1e 1e 32 1e 3 0
c8 a a 12c a a c8 14 a 1 0
ffffffce a a 0 14 14 fffffff6 1e 1e 5 1
1e 1e 1e 32 1e 1e 1e 32 1e 1f 1
